//--- logic/chdr_pkg.sv
// CHDR packet format definitions
// Bus and EPID widths, packet type codes, header and management header views
`default_nettype none

package chdr_pkg;

  // --------------------
  // Widths and codes
  // --------------------

  // Width of one CHDR bus word
  localparam int CHDR_W = 64;

  // Endpoint IDs are 16 bits wide everywhere in the network
  localparam int EPID_W = 16;

  // Packet type code carried by management packets
  localparam logic [2:0] PKT_TYPE_MGMT = 3'd1;

  // Discovery packets are addressed to this endpoint
  localparam logic [EPID_W-1:0] NULL_EPID = 16'd0;

  // --------------------
  // Word views
  // --------------------

  // First word of every CHDR packet
  typedef struct packed {
    logic [5:0]        vc;
    logic              eob;
    logic              eov;
    logic [2:0]        pkt_type;
    logic [4:0]        num_mdata;
    logic [15:0]       seq_num;
    logic [15:0]       length;
    logic [EPID_W-1:0] dst_epid;
  } chdr_header_t;

  // Second word of a management packet
  typedef struct packed {
    logic [15:0]       prot_ver;
    logic [2:0]        chdr_w;
    logic [18:0]       rsvd;
    logic [9:0]        num_hops;
    logic [EPID_W-1:0] src_epid;
  } mgmt_header_t;

  // One bus word, seen as a CHDR header on the first beat and as a
  // management header on the second beat of a management packet
  typedef union packed {
    chdr_header_t hdr;
    mgmt_header_t mgmt;
  } chdr_word_u;

endpackage

`default_nettype wire

//--- logic/rtn_table_pkg.sv
// Return-address table definitions
// Table depth, entry index width and stored tuser width
`default_nettype none

package rtn_table_pkg;

  // Width of the transport metadata stored per endpoint
  localparam int USER_W = 16;

  // Number of entries in the table
  localparam int TBL_DEPTH = 8;

  // Index width for one entry out of TBL_DEPTH
  localparam int TBL_IDX_W = 3;

endpackage

`default_nettype wire

//--- logic/rtn_addr_learner.sv
// Ingress pass-through with management packet snooping
// Issues a table insert for each management packet seen
`default_nettype none

module rtn_addr_learner (
  input  logic                              clk,
  input  logic                              rst,
  input  chdr_pkg::chdr_word_u              i_tdata,
  input  logic [rtn_table_pkg::USER_W-1:0]  i_tuser,
  input  logic                              i_tlast,
  input  logic                              i_tvalid,
  input  logic                              i_tready,
  output logic                              o_tready,
  output logic [chdr_pkg::CHDR_W-1:0]       o_tdata,
  output logic                              o_tlast,
  output logic                              o_tvalid,
  output logic                              o_ins_stb,
  output logic [chdr_pkg::EPID_W-1:0]       o_ins_key,
  output logic [rtn_table_pkg::USER_W-1:0]  o_ins_val
);

  logic                             xfer;
  logic                             hdr_beat;
  logic                             armed;
  logic [rtn_table_pkg::USER_W-1:0] tuser_cap;

  // The stream itself passes without any register in the way
  assign o_tdata  = i_tdata;
  assign o_tlast  = i_tlast;
  assign o_tvalid = i_tvalid;
  assign o_tready = i_tready;

  assign xfer = i_tvalid && i_tready;

  // Beat tracking and the insert pulse
  // A management header with more beats to follow arms the learner, and the
  // very next beat fires the insert one cycle after it is transferred
  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_beat  <= 1'b1;
      armed     <= 1'b0;
      o_ins_stb <= 1'b0;
    end else begin
      o_ins_stb <= 1'b0;
      if (xfer) begin
        hdr_beat <= i_tlast;
        if (hdr_beat) begin
          // Header-only packets carry no source EPID and are skipped
          armed <= (i_tdata.hdr.pkt_type == chdr_pkg::PKT_TYPE_MGMT) && !i_tlast;
        end else begin
          armed     <= 1'b0;
          o_ins_stb <= armed;
        end
      end
    end
  end

  // Captured tuser and the insert key and value
  always_ff @(posedge clk) begin
    if (xfer && hdr_beat) begin
      tuser_cap <= i_tuser;
    end
    if (xfer && !hdr_beat && armed) begin
      o_ins_key <= i_tdata.mgmt.src_epid;
      o_ins_val <= tuser_cap;
    end
  end

endmodule

`default_nettype wire

//--- logic/disc_filter.sv
// Discovery packet filter on the RFNoC side
// Drops management packets addressed to the null EPID
`default_nettype none

module disc_filter (
  input  logic                        clk,
  input  logic                        rst,
  input  chdr_pkg::chdr_word_u        i_tdata,
  input  logic                        i_tlast,
  input  logic                        i_tvalid,
  input  logic                        i_tready,
  output logic                        o_tready,
  output logic [chdr_pkg::CHDR_W-1:0] o_tdata,
  output logic                        o_tlast,
  output logic                        o_tvalid
);

  logic hdr_beat;
  logic is_disc;
  logic drop_r;
  logic drop;
  logic xfer;

  // Discovery packets are management packets sent to the null EPID
  assign is_disc = (i_tdata.hdr.pkt_type == chdr_pkg::PKT_TYPE_MGMT) &&
                   (i_tdata.hdr.dst_epid == chdr_pkg::NULL_EPID);

  // The header decides for itself, later beats follow the stored decision
  assign drop = hdr_beat ? is_disc : drop_r;

  // A dropped beat is taken at once and never shown downstream
  assign o_tdata  = i_tdata;
  assign o_tlast  = i_tlast;
  assign o_tvalid = i_tvalid && !drop;
  assign o_tready = drop || i_tready;

  assign xfer = i_tvalid && o_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_beat <= 1'b1;
      drop_r   <= 1'b0;
    end else if (xfer) begin
      hdr_beat <= i_tlast;
      // Hold the header decision until tlast goes by
      if (hdr_beat) begin
        drop_r <= is_disc;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/egress_tagger.sv
// Egress tagger toward the transport
// Holds each packet at its header until the table returns its tuser
`default_nettype none

module egress_tagger (
  input  logic                              clk,
  input  logic                              rst,
  input  chdr_pkg::chdr_word_u              i_tdata,
  input  logic                              i_tlast,
  input  logic                              i_tvalid,
  input  logic                              i_xport_tready,
  input  logic                              i_done_stb,
  input  logic                              i_match,
  input  logic [rtn_table_pkg::USER_W-1:0]  i_val,
  output logic                              o_tready,
  output logic [chdr_pkg::CHDR_W-1:0]       o_xport_tdata,
  output logic [rtn_table_pkg::USER_W-1:0]  o_xport_tuser,
  output logic                              o_xport_tlast,
  output logic                              o_xport_tvalid,
  output logic                              o_lookup_stb,
  output logic [chdr_pkg::EPID_W-1:0]       o_lookup_key
);

  // Controller state, idle when neither flag is set
  logic st_wait;
  logic st_pass;
  logic st_idle;
  logic xfer;

  assign st_idle = !st_wait && !st_pass;

  // --------------------
  // Output stream
  // --------------------

  // Nothing moves until the tuser is known, then words flow freely
  assign o_xport_tdata  = i_tdata;
  assign o_xport_tlast  = i_tlast;
  assign o_xport_tvalid = st_pass && i_tvalid;
  assign o_tready       = st_pass && i_xport_tready;

  assign xfer = st_pass && i_tvalid && i_xport_tready;

  // --------------------
  // Controller
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      st_wait      <= 1'b0;
      st_pass      <= 1'b0;
      o_lookup_stb <= 1'b0;
    end else begin
      o_lookup_stb <= 1'b0;
      if (st_idle) begin
        // A waiting header starts one search
        if (i_tvalid) begin
          o_lookup_stb <= 1'b1;
          st_wait      <= 1'b1;
        end
      end else if (st_wait) begin
        if (i_done_stb) begin
          st_wait <= 1'b0;
          st_pass <= 1'b1;
        end
      end else if (xfer && i_tlast) begin
        st_pass <= 1'b0;
      end
    end
  end

  // Search key and result tuser
  // The tuser stays put until the next packet's search completes
  always_ff @(posedge clk) begin
    if (st_idle && i_tvalid) begin
      o_lookup_key <= i_tdata.hdr.dst_epid;
    end
    if (st_wait && i_done_stb) begin
      o_xport_tuser <= i_match ? i_val : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/rtn_table_alloc.sv
// Slot allocator for table inserts
// Lowest free entry first, round-robin replacement when the table is full
`default_nettype none

module rtn_table_alloc (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_ins_stb,
  input  logic [rtn_table_pkg::TBL_DEPTH-1:0] i_valid_vec,
  output logic [rtn_table_pkg::TBL_DEPTH-1:0] o_wr_en
);

  logic [rtn_table_pkg::TBL_IDX_W-1:0] rr_ptr;
  logic [rtn_table_pkg::TBL_IDX_W-1:0] free_idx;
  logic [rtn_table_pkg::TBL_IDX_W-1:0] slot;
  logic                                full;

  // Find the lowest-indexed invalid entry
  // Scanning downward lets the lowest index win
  always_comb begin
    free_idx = '0;
    full     = 1'b1;
    for (int i = rtn_table_pkg::TBL_DEPTH - 1; i >= 0; i--) begin
      if (!i_valid_vec[i]) begin
        free_idx = rtn_table_pkg::TBL_IDX_W'(i);
        full     = 1'b0;
      end
    end
  end

  assign slot = full ? rr_ptr : free_idx;

  // Exactly one write enable per insert, none otherwise
  always_comb begin
    o_wr_en = '0;
    if (i_ins_stb) begin
      o_wr_en[slot] = 1'b1;
    end
  end

  // Replacement pointer moves only when it was used
  // It wraps naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (i_ins_stb && full) begin
      rr_ptr <= rr_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/rtn_table_entry.sv
// One return-address table entry with its own key comparator
`default_nettype none

module rtn_table_entry (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_wr_en,
  input  logic                              i_ins_stb,
  input  logic [chdr_pkg::EPID_W-1:0]       i_ins_key,
  input  logic [rtn_table_pkg::USER_W-1:0]  i_ins_val,
  input  logic                              i_lookup_stb,
  input  logic [chdr_pkg::EPID_W-1:0]       i_lookup_key,
  output logic                              o_valid,
  output logic                              o_hit,
  output logic [rtn_table_pkg::USER_W-1:0]  o_val
);

  logic [chdr_pkg::EPID_W-1:0] key_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
      o_hit   <= 1'b0;
    end else begin
      if (i_wr_en) begin
        o_valid <= 1'b1;
      end else if (i_ins_stb && (i_ins_key == key_r)) begin
        // The same key is being written elsewhere, so this copy goes stale
        o_valid <= 1'b0;
      end
      // Hit is a pulse that lines up one cycle after the lookup
      o_hit <= i_lookup_stb && o_valid && (i_lookup_key == key_r);
    end
  end

  // Key and value storage
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      key_r <= i_ins_key;
      o_val <= i_ins_val;
    end
  end

endmodule

`default_nettype wire

//--- logic/rtn_table_select.sv
// Search result selector
// Folds per-entry hits into one match flag and value
`default_nettype none

module rtn_table_select (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_lookup_stb,
  input  logic [rtn_table_pkg::TBL_DEPTH-1:0] i_hit_vec,
  input  logic [rtn_table_pkg::TBL_DEPTH-1:0][rtn_table_pkg::USER_W-1:0] i_val_vec,
  output logic                                o_done_stb,
  output logic                                o_match,
  output logic [rtn_table_pkg::USER_W-1:0]    o_val
);

  logic                             hits_ready;
  logic [rtn_table_pkg::USER_W-1:0] hit_val;

  // At most one entry hits, so an OR of the masked values picks it out
  always_comb begin
    hit_val = '0;
    for (int i = 0; i < rtn_table_pkg::TBL_DEPTH; i++) begin
      if (i_hit_vec[i]) begin
        hit_val = hit_val | i_val_vec[i];
      end
    end
  end

  // Hits become present one cycle after the lookup pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      hits_ready <= 1'b0;
      o_done_stb <= 1'b0;
    end else begin
      hits_ready <= i_lookup_stb;
      o_done_stb <= hits_ready;
    end
  end

  always_ff @(posedge clk) begin
    o_match <= |i_hit_vec;
    o_val   <= hit_val;
  end

endmodule

`default_nettype wire

//--- logic/xport_adapter_top.sv
// Transport adapter top level
// Ingress learner, discovery filter, egress tagger and the return-address table
`default_nettype none

module xport_adapter_top (
  input  logic                               clk,
  input  logic                               rst,
  // Transport in
  input  logic [chdr_pkg::CHDR_W-1:0]        i_xport_tdata,
  input  logic [rtn_table_pkg::USER_W-1:0]   i_xport_tuser,
  input  logic                               i_xport_tlast,
  input  logic                               i_xport_tvalid,
  output logic                               o_xport_in_tready,
  // RFNoC out
  output logic [chdr_pkg::CHDR_W-1:0]        o_rfnoc_tdata,
  output logic                               o_rfnoc_tlast,
  output logic                               o_rfnoc_tvalid,
  input  logic                               i_rfnoc_tready,
  // RFNoC in
  input  logic [chdr_pkg::CHDR_W-1:0]        i_rfnoc_tdata,
  input  logic                               i_rfnoc_tlast,
  input  logic                               i_rfnoc_tvalid,
  output logic                               o_rfnoc_in_tready,
  // Transport out
  output logic [chdr_pkg::CHDR_W-1:0]        o_xport_tdata,
  output logic [rtn_table_pkg::USER_W-1:0]   o_xport_tuser,
  output logic                               o_xport_tlast,
  output logic                               o_xport_tvalid,
  input  logic                               i_xport_tready
);

  // Insert strobe from the learner into the table
  logic                              ins_stb;
  logic [chdr_pkg::EPID_W-1:0]       ins_key;
  logic [rtn_table_pkg::USER_W-1:0]  ins_val;

  // Search request from the tagger and the result from the selector
  logic                              lookup_stb;
  logic [chdr_pkg::EPID_W-1:0]       lookup_key;
  logic                              done_stb;
  logic                              match;
  logic [rtn_table_pkg::USER_W-1:0]  match_val;

  // Per-entry state of the table
  logic [rtn_table_pkg::TBL_DEPTH-1:0] wr_en;
  logic [rtn_table_pkg::TBL_DEPTH-1:0] valid_vec;
  logic [rtn_table_pkg::TBL_DEPTH-1:0] hit_vec;
  logic [rtn_table_pkg::TBL_DEPTH-1:0][rtn_table_pkg::USER_W-1:0] val_vec;

  // Filtered RFNoC stream on its way to the tagger
  logic [chdr_pkg::CHDR_W-1:0] f2t_tdata;
  logic                        f2t_tlast;
  logic                        f2t_tvalid;
  logic                        f2t_tready;

  // --------------------
  // Ingress path
  // --------------------

  rtn_addr_learner learner_i (
    .clk       (clk),
    .rst       (rst),
    .i_tdata   (i_xport_tdata),
    .i_tuser   (i_xport_tuser),
    .i_tlast   (i_xport_tlast),
    .i_tvalid  (i_xport_tvalid),
    .i_tready  (i_rfnoc_tready),
    .o_tready  (o_xport_in_tready),
    .o_tdata   (o_rfnoc_tdata),
    .o_tlast   (o_rfnoc_tlast),
    .o_tvalid  (o_rfnoc_tvalid),
    .o_ins_stb (ins_stb),
    .o_ins_key (ins_key),
    .o_ins_val (ins_val)
  );

  // --------------------
  // Egress path
  // --------------------

  disc_filter filter_i (
    .clk      (clk),
    .rst      (rst),
    .i_tdata  (i_rfnoc_tdata),
    .i_tlast  (i_rfnoc_tlast),
    .i_tvalid (i_rfnoc_tvalid),
    .i_tready (f2t_tready),
    .o_tready (o_rfnoc_in_tready),
    .o_tdata  (f2t_tdata),
    .o_tlast  (f2t_tlast),
    .o_tvalid (f2t_tvalid)
  );

  egress_tagger tagger_i (
    .clk            (clk),
    .rst            (rst),
    .i_tdata        (f2t_tdata),
    .i_tlast        (f2t_tlast),
    .i_tvalid       (f2t_tvalid),
    .i_xport_tready (i_xport_tready),
    .i_done_stb     (done_stb),
    .i_match        (match),
    .i_val          (match_val),
    .o_tready       (f2t_tready),
    .o_xport_tdata  (o_xport_tdata),
    .o_xport_tuser  (o_xport_tuser),
    .o_xport_tlast  (o_xport_tlast),
    .o_xport_tvalid (o_xport_tvalid),
    .o_lookup_stb   (lookup_stb),
    .o_lookup_key   (lookup_key)
  );

  // --------------------
  // Return-address table
  // --------------------

  rtn_table_alloc alloc_i (
    .clk         (clk),
    .rst         (rst),
    .i_ins_stb   (ins_stb),
    .i_valid_vec (valid_vec),
    .o_wr_en     (wr_en)
  );

  // One comparator per entry, so a search takes a single cycle for all of them
  for (genvar i = 0; i < rtn_table_pkg::TBL_DEPTH; i++) begin : gen_entry
    rtn_table_entry entry_i (
      .clk          (clk),
      .rst          (rst),
      .i_wr_en      (wr_en[i]),
      .i_ins_stb    (ins_stb),
      .i_ins_key    (ins_key),
      .i_ins_val    (ins_val),
      .i_lookup_stb (lookup_stb),
      .i_lookup_key (lookup_key),
      .o_valid      (valid_vec[i]),
      .o_hit        (hit_vec[i]),
      .o_val        (val_vec[i])
    );
  end

  rtn_table_select select_i (
    .clk          (clk),
    .rst          (rst),
    .i_lookup_stb (lookup_stb),
    .i_hit_vec    (hit_vec),
    .i_val_vec    (val_vec),
    .o_done_stb   (done_stb),
    .o_match      (match),
    .o_val        (match_val)
  );

endmodule

`default_nettype wire

//--- dv/tb_vectors.svh
// Stimulus rows for the transport adapter testbench
// Row layout, second-word helper and the ordered list of packets
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each add_row call gives the direction, packet type, header destination EPID,
// second word, beat count, input tuser, expected drop and expected output tuser

localparam logic       FROM_XPORT = 1'b0;
localparam logic       FROM_RFNOC = 1'b1;
localparam logic [2:0] PKT_MGMT   = 3'd1;
localparam logic [2:0] PKT_DATA   = 3'd6;

// Filler second word for packets whose second word carries no meaning here
localparam logic [63:0] ANY_W2 = 64'h0123_4567_89AB_CDEF;

typedef struct packed {
  logic        from_rfnoc;
  logic [2:0]  pkt_type;
  logic [15:0] dst_epid;
  logic [63:0] word2;
  logic [7:0]  beats;
  logic [15:0] tuser_in;
  logic        drop;
  logic [15:0] tuser_exp;
} vec_t;

vec_t vecs[$];

// Management header word with version 1, one hop and the source EPID in the low bits
function automatic logic [63:0] mgmt_word(input logic [15:0] src);
  return {16'h0001, 3'd0, 19'd0, 10'd1, src};
endfunction

task automatic add_row(input logic rf, input logic [2:0] ptype, input logic [15:0] dst,
                       input logic [63:0] w2, input int beats, input logic [15:0] u,
                       input logic drop, input logic [15:0] u_exp);
  vec_t v;
  v.from_rfnoc = rf;
  v.pkt_type   = ptype;
  v.dst_epid   = dst;
  v.word2      = w2;
  v.beats      = 8'(beats);
  v.tuser_in   = u;
  v.drop       = drop;
  v.tuser_exp  = u_exp;
  vecs.push_back(v);
endtask

task automatic load_vectors();
  // Learn 0x11, then look it up, miss on an unknown EPID and filter discovery
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0011), 3, 16'hA011, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0011, ANY_W2, 4, 16'h0000, 0, 16'hA011);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0099, ANY_W2, 2, 16'h0000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_MGMT, 16'h0000, mgmt_word(16'h0042), 3, 16'h0000, 1, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0011, ANY_W2, 1, 16'h0000, 0, 16'hA011);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0000, ANY_W2, 2, 16'h0000, 0, 16'h0000);
  // Data and header-only management packets teach nothing
  add_row(FROM_XPORT, PKT_DATA, 16'h0011, mgmt_word(16'h0011), 3, 16'hFFFF, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0011, ANY_W2, 1, 16'hBEEF, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0011, ANY_W2, 2, 16'h0000, 0, 16'hA011);
  // Relearning 0x11 moves it to entry 1 with the new tuser
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0011), 2, 16'hB011, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0011, ANY_W2, 3, 16'h0000, 0, 16'hB011);
  // Filling the table puts 0x21 in entry 0 and 0x22 to 0x27 in entries 2 to 7
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0021), 2, 16'hC021, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0022), 3, 16'hC022, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0023), 2, 16'hC023, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0024), 4, 16'hC024, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0025), 2, 16'hC025, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0026), 2, 16'hC026, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0027), 5, 16'hC027, 0, 16'h0000);
  // The table is full, so round robin evicts 0x21 in entry 0 and then 0x11 in entry 1
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0028), 2, 16'hC028, 0, 16'h0000);
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0029), 2, 16'hC029, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0021, ANY_W2, 2, 16'h0000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0011, ANY_W2, 3, 16'h0000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0028, ANY_W2, 2, 16'h0000, 0, 16'hC028);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0022, ANY_W2, 4, 16'h0000, 0, 16'hC022);
  // Relearning 0x29 lands in entry 2, evicting 0x22 and freeing entry 1
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0029), 3, 16'hD029, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0022, ANY_W2, 2, 16'h0000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0029, ANY_W2, 2, 16'h0000, 0, 16'hD029);
  // EPID 0 is learned into the free entry 1 while discovery packets are still dropped
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h0000), 2, 16'hE000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0000, ANY_W2, 2, 16'h0000, 0, 16'hE000);
  add_row(FROM_RFNOC, PKT_MGMT, 16'h0000, mgmt_word(16'h0042), 2, 16'h0000, 1, 16'h0000);
  add_row(FROM_RFNOC, PKT_MGMT, 16'h0023, mgmt_word(16'h0042), 2, 16'h0000, 0, 16'hC023);
  // Round robin resumes at entry 3 and evicts 0x23
  add_row(FROM_XPORT, PKT_MGMT, 16'h0000, mgmt_word(16'h002A), 2, 16'hC02A, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0023, ANY_W2, 2, 16'h0000, 0, 16'h0000);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0024, ANY_W2, 3, 16'h0000, 0, 16'hC024);
  add_row(FROM_RFNOC, PKT_DATA, 16'h0027, ANY_W2, 5, 16'h0000, 0, 16'hC027);
endtask

`endif

//--- dv/tb_xport_adapter.sv
// Testbench for the transport adapter
// Clock, packet driver, output monitors, random back-pressure and watchdog
`default_nettype none

module tb_xport_adapter;

  localparam int CLK_PERIOD = 40;

  logic        clk;
  logic        rst;
  logic [63:0] i_xport_tdata;
  logic [15:0] i_xport_tuser;
  logic        i_xport_tlast;
  logic        i_xport_tvalid;
  logic        o_xport_in_tready;
  logic [63:0] o_rfnoc_tdata;
  logic        o_rfnoc_tlast;
  logic        o_rfnoc_tvalid;
  logic        i_rfnoc_tready;
  logic [63:0] i_rfnoc_tdata;
  logic        i_rfnoc_tlast;
  logic        i_rfnoc_tvalid;
  logic        o_rfnoc_in_tready;
  logic [63:0] o_xport_tdata;
  logic [15:0] o_xport_tuser;
  logic        o_xport_tlast;
  logic        o_xport_tvalid;
  logic        i_xport_tready;

  `include "tb_vectors.svh"

  // One expected word on either output
  typedef struct packed {
    logic [63:0] data;
    logic [15:0] user;
    logic        last;
  } exp_t;

  exp_t        rf_q[$];
  exp_t        xp_q[$];
  exp_t        rf_exp;
  exp_t        xp_exp;
  int          errors;
  int          rows_passed;
  int          rows_failed;
  int          total_beats;
  logic [31:0] lfsr;
  logic        rnd_bit;
  logic [31:0] payload_cnt;

  xport_adapter_top dut_i (
    .clk               (clk),
    .rst               (rst),
    .i_xport_tdata     (i_xport_tdata),
    .i_xport_tuser     (i_xport_tuser),
    .i_xport_tlast     (i_xport_tlast),
    .i_xport_tvalid    (i_xport_tvalid),
    .o_xport_in_tready (o_xport_in_tready),
    .o_rfnoc_tdata     (o_rfnoc_tdata),
    .o_rfnoc_tlast     (o_rfnoc_tlast),
    .o_rfnoc_tvalid    (o_rfnoc_tvalid),
    .i_rfnoc_tready    (i_rfnoc_tready),
    .i_rfnoc_tdata     (i_rfnoc_tdata),
    .i_rfnoc_tlast     (i_rfnoc_tlast),
    .i_rfnoc_tvalid    (i_rfnoc_tvalid),
    .o_rfnoc_in_tready (o_rfnoc_in_tready),
    .o_xport_tdata     (o_xport_tdata),
    .o_xport_tuser     (o_xport_tuser),
    .o_xport_tlast     (o_xport_tlast),
    .o_xport_tvalid    (o_xport_tvalid),
    .i_xport_tready    (i_xport_tready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // First word of a packet from the row's header fields
  function automatic logic [63:0] make_header(input vec_t v, input int seq);
    chdr_pkg::chdr_header_t h;
    h          = '0;
    h.pkt_type = v.pkt_type;
    h.seq_num  = 16'(seq);
    h.length   = 16'(v.beats * 8);
    h.dst_epid = v.dst_epid;
    return h;
  endfunction

  // Holds one word on the chosen input until the DUT takes it
  task automatic send_word(input logic rf, input logic [63:0] d, input logic [15:0] u,
                           input logic last);
    logic acc;
    if (rf) begin
      i_rfnoc_tdata  = d;
      i_rfnoc_tlast  = last;
      i_rfnoc_tvalid = 1'b1;
    end else begin
      i_xport_tdata  = d;
      i_xport_tuser  = u;
      i_xport_tlast  = last;
      i_xport_tvalid = 1'b1;
    end
    acc = 1'b0;
    while (!acc) begin
      // Ready is stable by the falling edge and holds through the next rising edge
      @(negedge clk);
      acc = rf ? o_rfnoc_in_tready : o_xport_in_tready;
      @(posedge clk);
      #2;
    end
    i_rfnoc_tvalid = 1'b0;
    i_xport_tvalid = 1'b0;
  endtask

  // Builds one packet, queues what should come out and sends it
  task automatic run_row(input int idx);
    vec_t        v;
    logic [63:0] words[$];
    int          err_before;
    logic        last;
    v          = vecs[idx];
    err_before = errors;
    words.push_back(make_header(v, idx));
    if (v.beats > 1) begin
      words.push_back(v.word2);
    end
    for (int b = 2; b < v.beats; b++) begin
      words.push_back({32'hDA7A_0000, payload_cnt});
      payload_cnt++;
    end
    // Transport packets reach RFNoC untouched, RFNoC packets gain the tuser
    for (int i = 0; i < words.size(); i++) begin
      last = (i == words.size() - 1);
      if (!v.from_rfnoc) begin
        rf_q.push_back({words[i], 16'h0000, last});
      end else if (!v.drop) begin
        xp_q.push_back({words[i], v.tuser_exp, last});
      end
    end
    for (int i = 0; i < words.size(); i++) begin
      send_word(v.from_rfnoc, words[i], v.tuser_in, i == words.size() - 1);
    end
    while (rf_q.size() != 0 || xp_q.size() != 0) begin
      @(negedge clk);
    end
    if (errors == err_before) begin
      rows_passed++;
      $display("Row %0d (%s) passed", idx, v.from_rfnoc ? "from RFNoC" : "from transport");
    end else begin
      rows_failed++;
      $display("Row %0d (%s) failed", idx, v.from_rfnoc ? "from RFNoC" : "from transport");
    end
  endtask

  // Both output readies, high three cycles in four on average
  initial begin
    lfsr = 32'h2228;
    forever begin
      @(posedge clk);
      #2;
      lfsr           = lfsr_step(lfsr);
      rnd_bit        = lfsr[0];
      lfsr           = lfsr_step(lfsr);
      i_rfnoc_tready = rnd_bit | lfsr[0];
      lfsr           = lfsr_step(lfsr);
      rnd_bit        = lfsr[0];
      lfsr           = lfsr_step(lfsr);
      i_xport_tready = rnd_bit | lfsr[0];
    end
  end

  // --------------------
  // Monitors
  // --------------------

  always @(negedge clk) begin
    if (!rst && o_rfnoc_tvalid && i_rfnoc_tready) begin
      if (rf_q.size() == 0) begin
        errors++;
        $display("Unexpected word %h on the RFNoC output at time %0t", o_rfnoc_tdata, $time);
      end else begin
        rf_exp = rf_q.pop_front();
        if (o_rfnoc_tdata !== rf_exp.data || o_rfnoc_tlast !== rf_exp.last) begin
          errors++;
          $display("FAILED at %0t: RFNoC output %h last %b, expected %h last %b", $time,
                   o_rfnoc_tdata, o_rfnoc_tlast, rf_exp.data, rf_exp.last);
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && o_xport_tvalid && i_xport_tready) begin
      if (xp_q.size() == 0) begin
        errors++;
        $display("Unexpected word %h on the transport output at time %0t", o_xport_tdata,
                 $time);
      end else begin
        xp_exp = xp_q.pop_front();
        if (o_xport_tdata !== xp_exp.data || o_xport_tlast !== xp_exp.last ||
            o_xport_tuser !== xp_exp.user) begin
          errors++;
          $display("FAILED at %0t: transport output %h tuser %h last %b, expected %h %h %b",
                   $time, o_xport_tdata, o_xport_tuser, o_xport_tlast, xp_exp.data,
                   xp_exp.user, xp_exp.last);
        end
      end
    end
  end

  // --------------------
  // Main sequence and watchdog
  // --------------------

  initial begin
    load_vectors();
    errors         = 0;
    rows_passed    = 0;
    rows_failed    = 0;
    payload_cnt    = '0;
    rst            = 1'b1;
    i_xport_tdata  = '0;
    i_xport_tuser  = '0;
    i_xport_tlast  = 1'b0;
    i_xport_tvalid = 1'b0;
    i_rfnoc_tdata  = '0;
    i_rfnoc_tlast  = 1'b0;
    i_rfnoc_tvalid = 1'b0;
    i_rfnoc_tready = 1'b0;
    i_xport_tready = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < vecs.size(); i++) begin
      run_row(i);
    end
    // Give a dropped packet time to show up if the filter let it through
    repeat (20) @(posedge clk);
    $display("Rows: %0d passed, %0d failed, %0d errors", rows_passed, rows_failed, errors);
    if (errors == 0 && rows_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #1;
    total_beats = 0;
    foreach (vecs[i]) begin
      total_beats += vecs[i].beats;
    end
    repeat (total_beats * 40 + 30) @(posedge clk);
    $display("Timeout: the run did not finish within %0d beats times 40 cycles", total_beats);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
logic/chdr_pkg.sv
logic/rtn_table_pkg.sv
logic/rtn_addr_learner.sv
logic/disc_filter.sv
logic/egress_tagger.sv
logic/rtn_table_alloc.sv
logic/rtn_table_entry.sv
logic/rtn_table_select.sv
logic/xport_adapter_top.sv
dv/tb_xport_adapter.sv

//--- Bender.yml
package:
  name: xport_adapter

sources:
  - logic/chdr_pkg.sv
  - logic/rtn_table_pkg.sv
  - logic/rtn_addr_learner.sv
  - logic/disc_filter.sv
  - logic/egress_tagger.sv
  - logic/rtn_table_alloc.sv
  - logic/rtn_table_entry.sv
  - logic/rtn_table_select.sv
  - logic/xport_adapter_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_xport_adapter.sv
